//--- alu_execute.sv
`timescale 1ns/1ps

module alu_execute import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    exec_en,
    input  word_t   operand_a,
    input  word_t   operand_b,
    input  alu_op_t alu_op,
    input  logic    invert_cond,
    output word_t   alu_result,
    output logic    take_branch
);

    word_t      result;
    logic [4:0] shamt;
    logic       cond;

    assign shamt = operand_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = operand_a + operand_b;
            ALU_SUB:    result = operand_a - operand_b;
            ALU_SLT:    result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU:   result = {31'b0, operand_a < operand_b};
            ALU_AND:    result = operand_a & operand_b;
            ALU_OR:     result = operand_a | operand_b;
            ALU_XOR:    result = operand_a ^ operand_b;
            ALU_SLL:    result = operand_a << shamt;
            ALU_SRL:    result = operand_a >> shamt;
            ALU_SRA:    result = word_t'($signed(operand_a) >>> shamt);
            ALU_PASS_B: result = operand_b;
            default:    result = '0;
        endcase
    end

    // sub means equality test, slt/sltu give the less-than bit
    assign cond = (alu_op == ALU_SUB) ? (operand_a == operand_b) : result[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_result  <= '0;
            take_branch <= 1'b0;
        end else if (exec_en) begin
            alu_result  <= result;
            take_branch <= cond ^ invert_cond;
        end
    end

endmodule

//--- apb_port.sv
`timescale 1ns/1ps

module apb_port import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  word_t     pwdata,
    output logic      start,
    output word_t     inst_word,
    output reg_addr_t rd_index,
    input  word_t     reg_value,
    input  word_t     pc,
    input  logic      done,
    input  logic      illegal,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr
);

    logic busy;     // instruction in flight
    logic is_reg;
    logic is_pc;
    logic is_instr;
    logic wr_instr;
    logic read_ok;

    // registers 0..31 live in the low 128 bytes, word aligned only
    assign is_reg   = (paddr[APB_AW-1:7] == REG_BASE[APB_AW-1:7]) && (paddr[1:0] == 2'b00);
    assign is_pc    = (paddr == PC_ADDR);
    assign is_instr = (paddr == INSTR_ADDR);
    assign wr_instr = pwrite & is_instr;
    assign read_ok  = ~pwrite & (is_reg | is_pc);

    assign rd_index = paddr[6:2];

    assign start = psel & ~penable & wr_instr & ~busy; // setup cycle only

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            inst_word <= pwdata;
        end
    end

    // wait states only while an instruction runs
    assign pready = busy ? done : 1'b1;

    assign prdata = is_pc ? pc : (is_reg ? reg_value : '0);

    assign pslverr = psel & penable & pready & (wr_instr ? illegal : ~read_ok);

endmodule

//--- compile.f
rv_pkg.sv
apb_port.sv
cycle_ctrl.sv
inst_decode.sv
alu_execute.sv
result_select.sv
reg_file.sv
rv_slice_top.sv
tb_rv_slice.sv

//--- cycle_ctrl.sv
`timescale 1ns/1ps

module cycle_ctrl import rv_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic load_inst,
    output logic exec_en,
    output logic wb_en,
    output logic done
);

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // fixed walk, one cycle per phase
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = DECODE;
                end
            end
            DECODE: begin
                state_nxt = EXECUTE;
            end
            EXECUTE: begin
                state_nxt = WRITEBACK;
            end
            WRITEBACK: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // one strobe per phase
    assign load_inst = (state == DECODE);
    assign exec_en   = (state == EXECUTE);
    assign wb_en     = (state == WRITEBACK);

    // apb side sees completion in the same cycle as the writeback
    assign done = (state == WRITEBACK);

endmodule

//--- inst_decode.sv
`timescale 1ns/1ps

module inst_decode import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_inst,
    input  word_t     inst_word,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    input  word_t     rs1_value,
    input  word_t     rs2_value,
    input  word_t     pc,
    output word_t     operand_a,
    output word_t     operand_b,
    output word_t     imm,
    output alu_op_t   alu_op,
    output logic      is_branch,
    output logic      is_jal,
    output logic      is_jalr,
    output logic      rd_write,
    output logic      illegal,
    output logic      invert_cond
);

    word_t      ir;
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_lui, is_auipc, is_op_imm, is_op;
    logic       op_imm_ok, op_ok, branch_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (load_inst) begin
            ir <= inst_word;
        end
    end

    assign opcode   = ir[6:0];
    assign f3       = ir[14:12];
    assign f7       = ir[31:25];
    assign rd_addr  = ir[11:7];
    assign rs1_addr = ir[19:15];
    assign rs2_addr = ir[24:20];

    // shifts need a clean funct7, only srai may use the alt encoding
    assign op_imm_ok = (f3 == F3_SLL) ? (f7 == F7_BASE) :
                       (f3 == F3_SRL_SRA) ? (f7 == F7_BASE || f7 == F7_ALT) : 1'b1;
    assign op_ok     = (f7 == F7_BASE) ||
                       (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
    assign branch_ok = (f3 == F3_BEQ) || (f3 == F3_BNE) || (f3 == F3_BLT) ||
                       (f3 == F3_BGE) || (f3 == F3_BLTU) || (f3 == F3_BGEU);

    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR) && (f3 == 3'b000);
    assign is_branch = (opcode == OPC_BRANCH) && branch_ok;
    assign is_op_imm = (opcode == OPC_OP_IMM) && op_imm_ok;
    assign is_op     = (opcode == OPC_OP) && op_ok;

    assign illegal  = ~(is_lui | is_auipc | is_jal | is_jalr | is_branch | is_op_imm | is_op);
    assign rd_write = is_lui | is_auipc | is_jal | is_jalr | is_op_imm | is_op;

    assign invert_cond = f3[0]; // bne / bge / bgeu

    always_comb begin
        alu_op = ALU_ADD; // auipc, jal, jalr
        if (is_lui) begin
            alu_op = ALU_PASS_B;
        end else if (is_branch) begin
            case (f3)
                F3_BEQ, F3_BNE: alu_op = ALU_SUB;
                F3_BLT, F3_BGE: alu_op = ALU_SLT;
                default:        alu_op = ALU_SLTU;
            endcase
        end else if (is_op | is_op_imm) begin
            case (f3)
                F3_ADD_SUB: alu_op = (is_op && f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                F3_SLL:     alu_op = ALU_SLL;
                F3_SLT:     alu_op = ALU_SLT;
                F3_SLTU:    alu_op = ALU_SLTU;
                F3_XOR:     alu_op = ALU_XOR;
                F3_SRL_SRA: alu_op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                F3_OR:      alu_op = ALU_OR;
                default:    alu_op = ALU_AND;
            endcase
        end
    end

    // i-format doubles as shamt, alu only looks at the low 5 bits
    always_comb begin
        if (is_lui | is_auipc) begin
            imm = {ir[31:12], 12'b0};
        end else if (is_jal) begin
            imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
        end else if (is_branch) begin
            imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
        end else begin
            imm = {{20{ir[31]}}, ir[31:20]};
        end
    end

    assign operand_a = (is_auipc | is_jal) ? pc : rs1_value;
    assign operand_b = (is_op | is_branch) ? rs2_value : imm;

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wb_en,
    input  logic      rd_write,
    input  reg_addr_t rd_addr,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t rd_index,
    input  word_t     rd_data,
    output word_t     rs1_value,
    output word_t     rs2_value,
    output word_t     reg_value
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && rd_write && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 hardwired
    assign rs1_value = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_value = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign reg_value = (rd_index == '0) ? '0 : regs[rd_index]; // apb read port

endmodule

//--- result_select.sv
`timescale 1ns/1ps

module result_select import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wb_en,
    input  word_t alu_result,
    input  word_t imm,
    input  word_t rs1_value,
    input  logic  is_branch,
    input  logic  is_jal,
    input  logic  is_jalr,
    input  logic  take_branch,
    input  logic  illegal,
    output word_t rd_data,
    output word_t pc
);

    word_t pc_plus4;
    word_t pc_nxt;
    word_t jalr_target;

    assign pc_plus4    = pc + 32'd4;
    assign jalr_target = (rs1_value + imm) & ~32'd1; // bit 0 dropped

    assign rd_data = (is_jal | is_jalr) ? pc_plus4 : alu_result; // link value

    always_comb begin
        if (illegal) begin
            pc_nxt = pc;
        end else if (is_jalr) begin
            pc_nxt = jalr_target;
        end else if (is_jal || (is_branch && take_branch)) begin
            pc_nxt = pc + imm;
        end else begin
            pc_nxt = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (wb_en) begin
            pc <= pc_nxt;
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build with verilator and run, the exit status carries the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_rv_slice
./obj_dir/Vtb_rv_slice

//--- rv_pkg.sv
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_AW    = 5;
    localparam int APB_AW    = 12;
    localparam int ALU_OPW   = 4;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [REG_AW-1:0]  reg_addr_t;
    typedef logic [ALU_OPW-1:0] alu_op_t;
    typedef logic [APB_AW-1:0]  apb_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        EXECUTE,
        WRITEBACK
    } state_t;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub / sra

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLT    = 4'd2;
    localparam alu_op_t ALU_SLTU   = 4'd3;
    localparam alu_op_t ALU_AND    = 4'd4;
    localparam alu_op_t ALU_OR     = 4'd5;
    localparam alu_op_t ALU_XOR    = 4'd6;
    localparam alu_op_t ALU_SLL    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10; // lui

    // apb map, register n at 4*n
    localparam apb_addr_t REG_BASE   = 12'h000;
    localparam apb_addr_t PC_ADDR    = 12'h080;
    localparam apb_addr_t INSTR_ADDR = 12'h084;

    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

//--- rv_slice_top.sv
`timescale 1ns/1ps

module rv_slice_top import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr
);

    logic      start, done, illegal;
    logic      load_inst, exec_en, wb_en;
    logic      is_branch, is_jal, is_jalr, rd_write, invert_cond;
    logic      take_branch;
    word_t     inst_word, reg_value, pc;
    word_t     rs1_value, rs2_value, operand_a, operand_b, imm;
    word_t     alu_result, rd_data;
    reg_addr_t rd_index, rs1_addr, rs2_addr, rd_addr;
    alu_op_t   alu_op;

    apb_port apb_port_i (
        .clk, .rst_n,
        .paddr, .psel, .penable, .pwrite, .pwdata,
        .start, .inst_word, .rd_index,
        .reg_value, .pc,
        .done, .illegal,
        .prdata, .pready, .pslverr
    );

    cycle_ctrl cycle_ctrl_i (
        .clk, .rst_n, .start,
        .load_inst, .exec_en, .wb_en, .done
    );

    inst_decode inst_decode_i (
        .clk, .rst_n, .load_inst, .inst_word,
        .rs1_addr, .rs2_addr, .rd_addr,
        .rs1_value, .rs2_value, .pc,
        .operand_a, .operand_b, .imm, .alu_op,
        .is_branch, .is_jal, .is_jalr, .rd_write, .illegal,
        .invert_cond
    );

    alu_execute alu_execute_i (
        .clk, .rst_n, .exec_en,
        .operand_a, .operand_b, .alu_op, .invert_cond,
        .alu_result, .take_branch
    );

    result_select result_select_i (
        .clk, .rst_n, .wb_en,
        .alu_result, .imm, .rs1_value,
        .is_branch, .is_jal, .is_jalr, .take_branch, .illegal,
        .rd_data, .pc
    );

    reg_file reg_file_i (
        .clk, .rst_n, .wb_en, .rd_write,
        .rd_addr, .rs1_addr, .rs2_addr, .rd_index,
        .rd_data,
        .rs1_value, .rs2_value, .reg_value
    );

endmodule

//--- tb_rv_slice.sv
`timescale 1ns/1ps

module tb_rv_slice import rv_pkg::*; ();

    localparam int MAX_WAIT = 16; // cycles per pready wait

    typedef struct {
        string     name;
        logic      write;
        apb_addr_t addr;
        word_t     data;
        word_t     exp_rdata;
        logic      exp_err;
    } entry_t;

    logic      clk = 1'b0;
    logic      rst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;
    entry_t    table_q[$];

    always #50 clk = ~clk;

    rv_slice_top dut_i (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    // base format encoders, field order from the ISA manual
    function automatic word_t imm_op(input logic [6:0] opc, input logic [2:0] f3,
                                     input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic word_t upper_op(input logic [6:0] opc, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t branch_op(input logic [2:0] f3, input int rs1, input int rs2,
                                        input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t jump_op(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic add_entry(input string name, input logic write, input apb_addr_t addr,
                             input word_t data, input word_t exp_rdata, input logic exp_err);
        table_q.push_back('{name, write, addr, data, exp_rdata, exp_err});
    endtask

    // instruction write, then read back rd and the pc
    task automatic step_instr(input string name, input word_t inst, input int rd,
                              input word_t rd_val, input word_t pc_val);
        add_entry(name, 1'b1, INSTR_ADDR, inst, 32'h0, 1'b0);
        add_entry({name, " rd"}, 1'b0, REG_BASE + apb_addr_t'(rd * 4), 32'h0, rd_val, 1'b0);
        add_entry({name, " pc"}, 1'b0, PC_ADDR, 32'h0, pc_val, 1'b0);
    endtask

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic apb_transfer(input entry_t e, output word_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        psel    <= 1'b1; // setup
        penable <= 1'b0;
        pwrite  <= e.write;
        paddr   <= e.addr;
        pwdata  <= e.data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk); // sample mid-cycle
        while (!pready && waited < MAX_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("transfer %s hung, pready stayed low for %0d cycles", e.name, MAX_WAIT);
            stop_run();
        end else begin
            rdata = prdata;
            err   = pslverr;
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic build_table();
        add_entry("reset pc", 1'b0, PC_ADDR, 32'h0, 32'h0, 1'b0);
        add_entry("reset x1", 1'b0, REG_BASE + 12'h004, 32'h0, 32'h0, 1'b0);
        add_entry("reset x31", 1'b0, REG_BASE + 12'h07C, 32'h0, 32'h0, 1'b0);
        step_instr("addi", imm_op(OPC_OP_IMM, F3_ADD_SUB, 1, 0, -5), 1, 32'hFFFF_FFFB, 32'h04);
        step_instr("addi max", imm_op(OPC_OP_IMM, F3_ADD_SUB, 2, 0, 'h7FF), 2, 32'h7FF, 32'h08);
        step_instr("slti", imm_op(OPC_OP_IMM, F3_SLT, 3, 1, -4), 3, 32'h1, 32'h0C);
        step_instr("sltiu", imm_op(OPC_OP_IMM, F3_SLTU, 4, 2, -1), 4, 32'h1, 32'h10);
        step_instr("xori", imm_op(OPC_OP_IMM, F3_XOR, 5, 2, -1), 5, 32'hFFFF_F800, 32'h14);
        step_instr("ori", imm_op(OPC_OP_IMM, F3_OR, 6, 2, -2048), 6, 32'hFFFF_FFFF, 32'h18);
        step_instr("andi", imm_op(OPC_OP_IMM, F3_AND, 7, 1, 'hF0), 7, 32'hF0, 32'h1C);
        step_instr("slli", imm_op(OPC_OP_IMM, F3_SLL, 8, 2, 20), 8, 32'h7FF0_0000, 32'h20);
        step_instr("srli", imm_op(OPC_OP_IMM, F3_SRL_SRA, 9, 1, 4), 9, 32'h0FFF_FFFF, 32'h24);
        step_instr("srai", imm_op(OPC_OP_IMM, F3_SRL_SRA, 10, 1, 'h401), 10, 32'hFFFF_FFFD,
                   32'h28);
        step_instr("addi to x0", imm_op(OPC_OP_IMM, F3_ADD_SUB, 0, 1, 1), 0, 32'h0, 32'h2C);
        step_instr("add", reg_op(F7_BASE, F3_ADD_SUB, 11, 1, 2), 11, 32'h7FA, 32'h30);
        step_instr("sub", reg_op(F7_ALT, F3_ADD_SUB, 12, 1, 2), 12, 32'hFFFF_F7FC, 32'h34);
        step_instr("sll", reg_op(F7_BASE, F3_SLL, 13, 2, 7), 13, 32'h07FF_0000, 32'h38);
        step_instr("slt", reg_op(F7_BASE, F3_SLT, 14, 2, 1), 14, 32'h0, 32'h3C);
        step_instr("sltu", reg_op(F7_BASE, F3_SLTU, 15, 2, 1), 15, 32'h1, 32'h40);
        step_instr("xor", reg_op(F7_BASE, F3_XOR, 16, 1, 5), 16, 32'h7FB, 32'h44);
        step_instr("srl", reg_op(F7_BASE, F3_SRL_SRA, 17, 5, 3), 17, 32'h7FFF_FC00, 32'h48);
        step_instr("sra", reg_op(F7_ALT, F3_SRL_SRA, 18, 5, 10), 18, 32'hFFFF_FFFF, 32'h4C);
        step_instr("or", reg_op(F7_BASE, F3_OR, 19, 7, 8), 19, 32'h7FF0_00F0, 32'h50);
        step_instr("and", reg_op(F7_BASE, F3_AND, 20, 5, 9), 20, 32'h0FFF_F800, 32'h54);
        step_instr("lui", upper_op(OPC_LUI, 21, 'hDEADB), 21, 32'hDEAD_B000, 32'h58);
        step_instr("auipc", upper_op(OPC_AUIPC, 22, 'h12345), 22, 32'h1234_5058, 32'h5C);
        // the rd field of a branch holds offset bits and must not be written back
        step_instr("beq taken", branch_op(F3_BEQ, 15, 3, 16), 16, 32'h7FB, 32'h6C);
        step_instr("beq not taken", branch_op(F3_BEQ, 1, 2, 16), 16, 32'h7FB, 32'h70);
        step_instr("bne taken", branch_op(F3_BNE, 1, 2, -8), 25, 32'h0, 32'h68);
        step_instr("bne not taken", branch_op(F3_BNE, 3, 15, 8), 8, 32'h7FF0_0000, 32'h6C);
        step_instr("blt taken", branch_op(F3_BLT, 1, 2, 12), 12, 32'hFFFF_F7FC, 32'h78);
        step_instr("blt not taken", branch_op(F3_BLT, 2, 1, 12), 12, 32'hFFFF_F7FC, 32'h7C);
        step_instr("bge taken", branch_op(F3_BGE, 2, 1, 2048), 1, 32'hFFFF_FFFB, 32'h87C);
        step_instr("bge not taken", branch_op(F3_BGE, 1, 2, 20), 20, 32'h0FFF_F800, 32'h880);
        step_instr("bltu taken", branch_op(F3_BLTU, 2, 1, 8), 8, 32'h7FF0_0000, 32'h888);
        step_instr("bltu not taken", branch_op(F3_BLTU, 1, 2, 8), 8, 32'h7FF0_0000, 32'h88C);
        step_instr("bgeu taken", branch_op(F3_BGEU, 1, 2, -2048), 1, 32'hFFFF_FFFB, 32'h8C);
        step_instr("bgeu not taken", branch_op(F3_BGEU, 2, 1, -32), 1, 32'hFFFF_FFFB, 32'h90);
        step_instr("jal", jump_op(23, 4096), 23, 32'h94, 32'h1090);
        step_instr("jalr", imm_op(OPC_JALR, 3'b000, 24, 2, 2), 24, 32'h1094, 32'h800);
        // unsupported encodings and bad accesses
        add_entry("bad opcode", 1'b1, INSTR_ADDR, 32'hFFFF_FFFF, 32'h0, 1'b1);
        add_entry("mul", 1'b1, INSTR_ADDR, reg_op(7'b0000001, 3'b000, 24, 1, 2), 32'h0, 1'b1);
        add_entry("pc after illegal", 1'b0, PC_ADDR, 32'h0, 32'h800, 1'b0);
        add_entry("x24 after illegal", 1'b0, REG_BASE + 12'h060, 32'h0, 32'h1094, 1'b0);
        add_entry("write x1 address", 1'b1, REG_BASE + 12'h004, 32'h1234_5678, 32'h0, 1'b1);
        add_entry("x1 after bad write", 1'b0, REG_BASE + 12'h004, 32'h0, 32'hFFFF_FFFB, 1'b0);
        add_entry("unmapped read", 1'b0, 12'h100, 32'h0, 32'h0, 1'b1);
    endtask

    initial begin
        word_t rdata;
        logic  err;
        rst_n   <= 1'b0;
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        foreach (table_q[i]) begin
            apb_transfer(table_q[i], rdata, err);
            assert (err == table_q[i].exp_err) else begin
                $display("MISMATCH %s pslverr expected %0b actual %0b",
                         table_q[i].name, table_q[i].exp_err, err);
                stop_run();
            end
            if (!table_q[i].write && !table_q[i].exp_err) begin // prdata only on good reads
                assert (rdata == table_q[i].exp_rdata) else begin
                    $display("MISMATCH %s expected %08h actual %08h",
                             table_q[i].name, table_q[i].exp_rdata, rdata);
                    stop_run();
                end
            end
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
